//--- flist.f
cw_bus_pkg.sv
cw_target_pkg.sv
usb_reg_bridge.sv
trigger_route.sv
target_io_ctrl.sv
status_leds.sv
cw_top.sv
tb_cw_top.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_cw_top
FLIST      := flist.f
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
FAIL_MSG   := Some tests failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_cw_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cw_top;

   localparam int WATCHDOG_NS = 20000;  // Well above the length of the full run

   logic       clk_usb_buf = 1'b0;
   logic       rst_i;
   logic       usb_cen_i;
   logic       usb_rdn_i;
   logic       usb_wrn_i;
   logic [7:0] usb_addr_i;
   logic [7:0] usb_din_i;
   logic [3:0] target_io_i;
   logic       pll_status_i;
   logic       sam_mosi_i;
   logic       sam_spck_i;
   logic       target_miso_i;
   logic [7:0] usb_dout_o;
   logic       usb_isout_o;
   logic       trigger_o;
   logic       led_clk1fail_o;
   logic       target_poweron_o;
   logic       target_nrst_o;
   logic       target_nrst_oe_o;
   logic       target_mosi_o;
   logic       target_mosi_oe_o;
   logic       target_sck_o;
   logic       target_sck_oe_o;
   logic       sam_miso_o;
   logic       sam_miso_oe_o;

   int         errors = 0;
   int         tests_run = 0;
   int         tests_failed = 0;
   int         edge_count = 0;   // Own count of trigger rising edges
   logic       trig_prev = 1'b0;

   cw_top #(.HEARTBEAT_BIT(3)) u_dut (.*);

   always #2 clk_usb_buf = ~clk_usb_buf;   // 4 ns period

   always @(negedge clk_usb_buf) begin
      if (trigger_o && !trig_prev) edge_count <= edge_count + 1;
      trig_prev <= trigger_o;
   end

   // Drive enable mirrors the sampled read strobe one cycle later
   assert property (@(posedge clk_usb_buf) disable iff (rst_i)
                    usb_isout_o == $past(!usb_rdn_i && !usb_cen_i))
      else begin
         $display("[ERROR] %0t usb_isout_o expected %0b got %0b", $time,
                  !$sampled(usb_isout_o), $sampled(usb_isout_o));
         errors++;
      end

   assert property (@(posedge clk_usb_buf) disable iff (rst_i) !target_poweron_o |->
                    !(target_nrst_oe_o || target_mosi_oe_o || target_sck_oe_o))
      else begin
         $display("[ERROR] %0t target enables expected 000 got %b%b%b", $time,
                  $sampled(target_nrst_oe_o), $sampled(target_mosi_oe_o),
                  $sampled(target_sck_oe_o));
         errors++;
      end

   task automatic expect_eq(input string name, input int exp, input int got);
      assert (exp == got)
         else begin
            $display("[ERROR] %0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
            errors++;
         end
   endtask

   task automatic end_test(input string name, input int errs_before);
      tests_run++;
      if (errors != errs_before) tests_failed++;
      $display("Test %0d %s: %s", tests_run, name, (errors == errs_before) ? "ok" : "FAILED");
   endtask

   task automatic usb_write(input logic [7:0] addr, input logic [7:0] data);
      @(negedge clk_usb_buf);
      usb_cen_i  = 1'b0;
      usb_addr_i = addr;
      usb_din_i  = data;
      usb_wrn_i  = 1'b0;
      repeat (4) @(negedge clk_usb_buf);
      usb_wrn_i = 1'b1;
      repeat (2) @(negedge clk_usb_buf);
   endtask

   task automatic usb_read(input logic [7:0] addr, output logic [7:0] data);
      @(negedge clk_usb_buf);
      usb_cen_i  = 1'b0;
      usb_addr_i = addr;
      usb_rdn_i  = 1'b0;
      repeat (4) @(negedge clk_usb_buf);
      data      = usb_dout_o;   // Valid from the third cycle on
      usb_rdn_i = 1'b1;
      repeat (2) @(negedge clk_usb_buf);
   endtask

   task automatic read_check(input logic [7:0] addr, input int exp, input string name);
      logic [7:0] data;
      usb_read(addr, data);
      expect_eq(name, exp, data);
   endtask

   // Chip enable high restarts the byte count
   task automatic end_window();
      @(negedge clk_usb_buf);
      usb_cen_i = 1'b1;
      @(negedge clk_usb_buf);
   endtask

   function automatic logic trig_model(input logic [3:0] mask, input logic [1:0] mode,
                                       input logic [3:0] io);
      logic all_high;
      all_high = (mask != 4'd0) && ((io & mask) == mask);
      case (mode)
         2'd1:    return all_high;
         2'd2:    return !all_high;
         default: return |(io & mask);   // OR, code 3 too
      endcase
   endfunction

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: run still going after %0d ns", WATCHDOG_NS);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      logic [7:0] rd;
      logic [7:0] hi;
      logic [7:0] v;
      logic [3:0] mask;
      logic [1:0] mode;
      logic       led_prev;
      int         base;
      int         toggles;
      int         errs;

      void'($urandom(58));
      rst_i         = 1'b1;
      usb_cen_i     = 1'b1;
      usb_rdn_i     = 1'b1;
      usb_wrn_i     = 1'b1;
      usb_addr_i    = 8'h00;
      usb_din_i     = 8'h00;
      target_io_i   = 4'h0;
      pll_status_i  = 1'b1;
      sam_mosi_i    = 1'b0;
      sam_spck_i    = 1'b0;
      target_miso_i = 1'b0;
      repeat (2) @(negedge clk_usb_buf);
      rst_i = 1'b0;

      errs = errors;
      @(negedge clk_usb_buf);
      expect_eq("usb_isout_o", 0, usb_isout_o);
      expect_eq("trigger_o", 0, trigger_o);
      expect_eq("target_poweron_o", 0, target_poweron_o);
      expect_eq("output enables", 0,
                {target_nrst_oe_o, target_mosi_oe_o, target_sck_oe_o, sam_miso_oe_o});
      expect_eq("led_clk1fail_o", !pll_status_i, led_clk1fail_o);
      read_check(cw_bus_pkg::REG_TRIG_MODE, 0, "trig mode");
      end_test("reset state", errs);

      errs = errors;
      repeat (4) begin
         v = 8'($urandom);
         usb_write(cw_bus_pkg::REG_TRIG_MASK, v);
         read_check(cw_bus_pkg::REG_TRIG_MASK, v & 8'h0F, "trig mask");
         usb_write(cw_bus_pkg::REG_TRIG_MODE, v);
         read_check(cw_bus_pkg::REG_TRIG_MODE, v & 8'h03, "trig mode");
         usb_write(cw_bus_pkg::REG_TARGET_PWR, v);
         read_check(cw_bus_pkg::REG_TARGET_PWR, v & 8'h01, "target pwr");
         usb_write(cw_bus_pkg::REG_TARGET_PROG, v);
         read_check(cw_bus_pkg::REG_TARGET_PROG, v & 8'h07, "target prog");
      end
      end_test("register read-back", errs);

      errs = errors;
      usb_write(cw_bus_pkg::REG_TRIG_MODE, 8'h00);   // OR with idle lines holds trigger low
      usb_write(cw_bus_pkg::REG_TRIG_COUNT, 8'h00);
      base = edge_count;
      repeat (12) begin
         mask = 4'($urandom);
         mode = 2'($urandom);
         usb_write(cw_bus_pkg::REG_TRIG_MASK, {4'h0, mask});
         usb_write(cw_bus_pkg::REG_TRIG_MODE, {6'h00, mode});
         target_io_i = 4'($urandom);
         repeat (4) @(negedge clk_usb_buf);
         expect_eq("trigger_o", trig_model(mask, mode, target_io_i), trigger_o);
      end
      end_window();
      usb_read(cw_bus_pkg::REG_TRIG_COUNT, rd);
      usb_read(cw_bus_pkg::REG_TRIG_COUNT, hi);   // Byte count 1, high byte
      expect_eq("trig count", edge_count - base, {hi, rd});
      usb_write(cw_bus_pkg::REG_TRIG_COUNT, 8'h5A);
      end_window();
      usb_read(cw_bus_pkg::REG_TRIG_COUNT, rd);
      usb_read(cw_bus_pkg::REG_TRIG_COUNT, hi);
      expect_eq("trig count after clear", 0, {hi, rd});
      end_test("trigger combine and count", errs);

      errs = errors;
      usb_write(cw_bus_pkg::REG_TARGET_PWR, 8'h01);
      usb_write(cw_bus_pkg::REG_TARGET_PROG, 8'(1 << cw_target_pkg::PROG_AVR_BIT));
      repeat (4) begin
         {sam_mosi_i, sam_spck_i, target_miso_i} = 3'($urandom);
         @(negedge clk_usb_buf);
         expect_eq("target_nrst_o", 0, target_nrst_o);
         expect_eq("target_nrst_oe_o", 1, target_nrst_oe_o);
         expect_eq("target_mosi_o", sam_mosi_i, target_mosi_o);
         expect_eq("target_sck_o", sam_spck_i, target_sck_o);
         expect_eq("mosi and sck enables", 3, {target_mosi_oe_o, target_sck_oe_o});
         expect_eq("sam_miso_o", target_miso_i, sam_miso_o);
         expect_eq("sam_miso_oe_o", 1, sam_miso_oe_o);
      end
      for (int p = 0; p < 4; p++) begin
         v = 8'h00;
         v[cw_target_pkg::PROG_NRST_EN_BIT]  = p[0];
         v[cw_target_pkg::PROG_NRST_VAL_BIT] = p[1];
         usb_write(cw_bus_pkg::REG_TARGET_PROG, v);
         expect_eq("target_nrst_oe_o", p[0], target_nrst_oe_o);
         if (p[0]) expect_eq("target_nrst_o", p[1], target_nrst_o);
      end
      usb_write(cw_bus_pkg::REG_TARGET_PROG, 8'h07);
      usb_write(cw_bus_pkg::REG_TARGET_PWR, 8'h00);
      expect_eq("target enables", 0, {target_nrst_oe_o, target_mosi_oe_o, target_sck_oe_o});
      expect_eq("target_poweron_o", 0, target_poweron_o);
      end_test("target pins", errs);

      errs = errors;
      usb_read(8'h55, rd);   // Unmapped
      read_check(cw_bus_pkg::REG_STATUS, {6'b0, pll_status_i, 1'b1}, "status");
      toggles  = 0;
      led_prev = led_clk1fail_o;
      repeat (64) begin
         @(negedge clk_usb_buf);
         if (led_clk1fail_o != led_prev) toggles++;
         led_prev = led_clk1fail_o;
      end
      expect_eq("led_clk1fail_o toggles", 8, toggles);   // 16 cycle period
      usb_write(cw_bus_pkg::REG_STATUS, 8'h01);
      read_check(cw_bus_pkg::REG_STATUS, {6'b0, pll_status_i, 1'b0}, "status");
      pll_status_i = 1'b0;
      @(negedge clk_usb_buf);
      expect_eq("led_clk1fail_o", 1, led_clk1fail_o);
      end_test("bus error and LED", errs);

      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- cw_top.sv
`timescale 1ns/10ps
`default_nettype none

module cw_top #(
   parameter int BYTECNT_W     = 7,
   parameter int HEARTBEAT_BIT = 22
) (
   input  wire                                  clk_usb_buf,
   input  wire                                  rst_i,
   input  wire                                  usb_cen_i,
   input  wire                                  usb_rdn_i,
   input  wire                                  usb_wrn_i,
   input  wire [cw_bus_pkg::ADDR_W-1:0]         usb_addr_i,
   input  wire [cw_bus_pkg::DATA_W-1:0]         usb_din_i,
   input  wire [cw_target_pkg::NUM_TRIG_IO-1:0] target_io_i,
   input  wire                                  pll_status_i,
   input  wire                                  sam_mosi_i,
   input  wire                                  sam_spck_i,
   input  wire                                  target_miso_i,
   output logic [cw_bus_pkg::DATA_W-1:0]        usb_dout_o,
   output logic                                 usb_isout_o,
   output logic                                 trigger_o,
   output logic                                 led_clk1fail_o,
   output logic                                 target_poweron_o,
   output logic                                 target_nrst_o,
   output logic                                 target_nrst_oe_o,
   output logic                                 target_mosi_o,
   output logic                                 target_mosi_oe_o,
   output logic                                 target_sck_o,
   output logic                                 target_sck_oe_o,
   output logic                                 sam_miso_o,
   output logic                                 sam_miso_oe_o
);

   logic [cw_bus_pkg::ADDR_W-1:0] reg_addr;
   logic [BYTECNT_W-1:0]          reg_bytecnt;
   logic [cw_bus_pkg::DATA_W-1:0] reg_wdata;
   logic                          reg_write;
   logic                          bus_error;
   logic [cw_bus_pkg::DATA_W-1:0] rdata_trig;
   logic [cw_bus_pkg::DATA_W-1:0] rdata_target;
   logic [cw_bus_pkg::DATA_W-1:0] rdata_status;
   logic [cw_bus_pkg::DATA_W-1:0] reg_rdata;

   // Unselected blocks return zero
   assign reg_rdata = rdata_trig | rdata_target | rdata_status;

   // Read pulse only paces the read-back capture inside the bridge
   usb_reg_bridge #(.BYTECNT_W(BYTECNT_W)) u_bridge (
      .clk_usb_buf   (clk_usb_buf),
      .rst_i         (rst_i),
      .usb_cen_i     (usb_cen_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_addr_i    (usb_addr_i),
      .usb_din_i     (usb_din_i),
      .reg_rdata_i   (reg_rdata),
      .usb_dout_o    (usb_dout_o),
      .usb_isout_o   (usb_isout_o),
      .reg_addr_o    (reg_addr),
      .reg_bytecnt_o (reg_bytecnt),
      .reg_wdata_o   (reg_wdata),
      .reg_write_o   (reg_write),
      .reg_read_o    (),
      .bus_error_o   (bus_error)
   );

   trigger_route #(.BYTECNT_W(BYTECNT_W)) u_trig (
      .clk_usb_buf   (clk_usb_buf),
      .rst_i         (rst_i),
      .reg_addr_i    (reg_addr),
      .reg_bytecnt_i (reg_bytecnt),
      .reg_wdata_i   (reg_wdata),
      .reg_write_i   (reg_write),
      .target_io_i   (target_io_i),
      .reg_rdata_o   (rdata_trig),
      .trigger_o     (trigger_o)
   );

   target_io_ctrl u_target (
      .clk_usb_buf      (clk_usb_buf),
      .rst_i            (rst_i),
      .reg_addr_i       (reg_addr),
      .reg_wdata_i      (reg_wdata),
      .reg_write_i      (reg_write),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .reg_rdata_o      (rdata_target),
      .target_poweron_o (target_poweron_o),
      .target_nrst_o    (target_nrst_o),
      .target_nrst_oe_o (target_nrst_oe_o),
      .target_mosi_o    (target_mosi_o),
      .target_mosi_oe_o (target_mosi_oe_o),
      .target_sck_o     (target_sck_o),
      .target_sck_oe_o  (target_sck_oe_o),
      .sam_miso_o       (sam_miso_o),
      .sam_miso_oe_o    (sam_miso_oe_o)
   );

   status_leds #(.HEARTBEAT_BIT(HEARTBEAT_BIT)) u_status (
      .clk_usb_buf    (clk_usb_buf),
      .rst_i          (rst_i),
      .reg_addr_i     (reg_addr),
      .reg_wdata_i    (reg_wdata),
      .reg_write_i    (reg_write),
      .bus_error_i    (bus_error),
      .pll_status_i   (pll_status_i),
      .reg_rdata_o    (rdata_status),
      .led_clk1fail_o (led_clk1fail_o)
   );

endmodule

`default_nettype wire

//--- status_leds.sv
`timescale 1ns/10ps
`default_nettype none

module status_leds #(
   parameter int HEARTBEAT_BIT = 22
) (
   input  wire                          clk_usb_buf,
   input  wire                          rst_i,
   input  wire [cw_bus_pkg::ADDR_W-1:0] reg_addr_i,
   input  wire [cw_bus_pkg::DATA_W-1:0] reg_wdata_i,
   input  wire                          reg_write_i,
   input  wire                          bus_error_i,
   input  wire                          pll_status_i,
   output logic [cw_bus_pkg::DATA_W-1:0] reg_rdata_o,
   output logic                          led_clk1fail_o
);

   logic [HEARTBEAT_BIT:0] heartbeat;
   logic                   error_flag;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) heartbeat <= '0;
      else       heartbeat <= heartbeat + 1'b1;
   end

   // Sticky until cleared by the host, a new error wins
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         error_flag <= 1'b0;
      end else if (bus_error_i) begin
         error_flag <= 1'b1;
      end else if (reg_write_i && (reg_addr_i == cw_bus_pkg::REG_STATUS)
                   && reg_wdata_i[0]) begin
         error_flag <= 1'b0;
      end
   end

   // Flash on error, else lit while the PLL is unlocked
   assign led_clk1fail_o = error_flag ? heartbeat[HEARTBEAT_BIT] : ~pll_status_i;

   assign reg_rdata_o = (reg_addr_i == cw_bus_pkg::REG_STATUS) ?
                        {6'b000000, pll_status_i, error_flag} : '0;

endmodule

`default_nettype wire

//--- target_io_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module target_io_ctrl (
   input  wire                          clk_usb_buf,
   input  wire                          rst_i,
   input  wire [cw_bus_pkg::ADDR_W-1:0] reg_addr_i,
   input  wire [cw_bus_pkg::DATA_W-1:0] reg_wdata_i,
   input  wire                          reg_write_i,
   input  wire                          sam_mosi_i,
   input  wire                          sam_spck_i,
   input  wire                          target_miso_i,
   output logic [cw_bus_pkg::DATA_W-1:0] reg_rdata_o,
   output logic                          target_poweron_o,
   output logic                          target_nrst_o,
   output logic                          target_nrst_oe_o,
   output logic                          target_mosi_o,
   output logic                          target_mosi_oe_o,
   output logic                          target_sck_o,
   output logic                          target_sck_oe_o,
   output logic                          sam_miso_o,
   output logic                          sam_miso_oe_o
);

   logic       pwr_on;
   logic [2:0] prog_reg;
   logic       avr_en;
   logic       nrst_en;
   logic       nrst_val;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         pwr_on   <= 1'b0;
         prog_reg <= '0;
      end else if (reg_write_i) begin
         if (reg_addr_i == cw_bus_pkg::REG_TARGET_PWR)
            pwr_on <= reg_wdata_i[cw_target_pkg::PWR_ON_BIT];
         if (reg_addr_i == cw_bus_pkg::REG_TARGET_PROG)
            prog_reg <= reg_wdata_i[2:0];
      end
   end

   assign avr_en   = prog_reg[cw_target_pkg::PROG_AVR_BIT];
   assign nrst_en  = prog_reg[cw_target_pkg::PROG_NRST_EN_BIT];
   assign nrst_val = prog_reg[cw_target_pkg::PROG_NRST_VAL_BIT];

   assign target_poweron_o = pwr_on;

   // Reset held low while programming
   assign target_nrst_o    = avr_en ? 1'b0 : nrst_val;
   assign target_nrst_oe_o = pwr_on & (avr_en | nrst_en);

   // SPI pass-through from the SAM
   assign target_mosi_o    = avr_en & sam_mosi_i;
   assign target_mosi_oe_o = pwr_on & avr_en;
   assign target_sck_o     = avr_en & sam_spck_i;
   assign target_sck_oe_o  = pwr_on & avr_en;

   assign sam_miso_o    = target_miso_i;
   assign sam_miso_oe_o = avr_en;   // SAM side is always powered

   always_comb begin
      case (reg_addr_i)
         cw_bus_pkg::REG_TARGET_PWR:  reg_rdata_o = {7'b0000000, pwr_on};
         cw_bus_pkg::REG_TARGET_PROG: reg_rdata_o = {5'b00000, prog_reg};
         default:                     reg_rdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- trigger_route.sv
`timescale 1ns/10ps
`default_nettype none

module trigger_route #(
   parameter int BYTECNT_W = 7
) (
   input  wire                                 clk_usb_buf,
   input  wire                                 rst_i,
   input  wire [cw_bus_pkg::ADDR_W-1:0]        reg_addr_i,
   input  wire [BYTECNT_W-1:0]                 reg_bytecnt_i,
   input  wire [cw_bus_pkg::DATA_W-1:0]        reg_wdata_i,
   input  wire                                 reg_write_i,
   input  wire [cw_target_pkg::NUM_TRIG_IO-1:0] target_io_i,
   output logic [cw_bus_pkg::DATA_W-1:0]       reg_rdata_o,
   output logic                                trigger_o
);

   logic [cw_target_pkg::NUM_TRIG_IO-1:0] trig_mask;
   cw_target_pkg::trig_mode_e             trig_mode;
   logic [cw_target_pkg::NUM_TRIG_IO-1:0] io_meta;
   logic [cw_target_pkg::NUM_TRIG_IO-1:0] io_sync;
   logic [cw_target_pkg::NUM_TRIG_IO-1:0] io_masked;
   logic                                  all_high;
   logic                                  trig_next;
   logic                                  trig_d;
   logic [15:0]                           trig_count;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         trig_mask <= '0;
         trig_mode <= cw_target_pkg::TRIG_OR;
      end else if (reg_write_i) begin
         if (reg_addr_i == cw_bus_pkg::REG_TRIG_MASK)
            trig_mask <= reg_wdata_i[cw_target_pkg::NUM_TRIG_IO-1:0];
         if (reg_addr_i == cw_bus_pkg::REG_TRIG_MODE)
            trig_mode <= cw_target_pkg::trig_mode_e'(reg_wdata_i[1:0]);
      end
   end

   // Two stage synchronizer, target IO is asynchronous
   always_ff @(posedge clk_usb_buf) begin
      io_meta <= target_io_i;
      io_sync <= io_meta;
   end

   assign io_masked = io_sync & trig_mask;
   assign all_high  = (trig_mask != '0) && (io_masked == trig_mask);

   always_comb begin
      case (trig_mode)
         cw_target_pkg::TRIG_AND:  trig_next = all_high;
         cw_target_pkg::TRIG_NAND: trig_next = ~all_high;
         default:                  trig_next = |io_masked;  // OR and the spare code
      endcase
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         trigger_o  <= 1'b0;
         trig_d     <= 1'b0;
         trig_count <= '0;
      end else begin
         trigger_o <= trig_next;
         trig_d    <= trigger_o;
         if (reg_write_i && (reg_addr_i == cw_bus_pkg::REG_TRIG_COUNT))
            trig_count <= '0;   // Any write clears
         else if (trigger_o && !trig_d && (trig_count != 16'hFFFF))
            trig_count <= trig_count + 16'd1;
      end
   end

   always_comb begin
      reg_rdata_o = '0;
      case (reg_addr_i)
         cw_bus_pkg::REG_TRIG_MASK:  reg_rdata_o = {4'b0000, trig_mask};
         cw_bus_pkg::REG_TRIG_MODE:  reg_rdata_o = {6'b000000, trig_mode};
         cw_bus_pkg::REG_TRIG_COUNT: begin
            if (reg_bytecnt_i == BYTECNT_W'(0))      reg_rdata_o = trig_count[7:0];
            else if (reg_bytecnt_i == BYTECNT_W'(1)) reg_rdata_o = trig_count[15:8];
         end
         default: reg_rdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- usb_reg_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module usb_reg_bridge #(
   parameter int BYTECNT_W = 7
) (
   input  wire                          clk_usb_buf,
   input  wire                          rst_i,
   input  wire                          usb_cen_i,
   input  wire                          usb_rdn_i,
   input  wire                          usb_wrn_i,
   input  wire [cw_bus_pkg::ADDR_W-1:0] usb_addr_i,
   input  wire [cw_bus_pkg::DATA_W-1:0] usb_din_i,
   input  wire [cw_bus_pkg::DATA_W-1:0] reg_rdata_i,
   output logic [cw_bus_pkg::DATA_W-1:0] usb_dout_o,
   output logic                          usb_isout_o,
   output logic [cw_bus_pkg::ADDR_W-1:0] reg_addr_o,
   output logic [BYTECNT_W-1:0]          reg_bytecnt_o,
   output logic [cw_bus_pkg::DATA_W-1:0] reg_wdata_o,
   output logic                          reg_write_o,
   output logic                          reg_read_o,
   output logic                          bus_error_o
);

   logic                          cen_q;
   logic                          rdn_q;
   logic                          wrn_q;
   logic                          rdn_qq;
   logic                          wrn_qq;
   logic [cw_bus_pkg::ADDR_W-1:0] addr_q;
   logic [cw_bus_pkg::DATA_W-1:0] din_q;
   logic                          addr_mapped;

   // Input register stage, strobes idle high
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         cen_q  <= 1'b1;
         rdn_q  <= 1'b1;
         wrn_q  <= 1'b1;
         rdn_qq <= 1'b1;
         wrn_qq <= 1'b1;
         addr_q <= '0;
      end else begin
         cen_q  <= usb_cen_i;
         rdn_q  <= usb_rdn_i;
         wrn_q  <= usb_wrn_i;
         rdn_qq <= rdn_q;   // Previous strobe level for edge detect
         wrn_qq <= wrn_q;
         addr_q <= usb_addr_i;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      din_q <= usb_din_i;
   end

   // One cycle pulses on the falling strobe edge
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         reg_write_o <= 1'b0;
         reg_read_o  <= 1'b0;
      end else begin
         reg_write_o <= wrn_qq & ~wrn_q & ~cen_q;
         reg_read_o  <= rdn_qq & ~rdn_q & ~cen_q;
      end
   end

   // Byte index within a multi-byte register
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         reg_bytecnt_o <= '0;
      end else if (usb_cen_i || (usb_addr_i != addr_q)) begin
         reg_bytecnt_o <= '0;   // New window or new register
      end else if (reg_write_o || reg_read_o) begin
         reg_bytecnt_o <= reg_bytecnt_o + BYTECNT_W'(1);
      end
   end

   // Read-back data held until the next read
   always_ff @(posedge clk_usb_buf) begin
      if (reg_read_o) begin
         usb_dout_o <= reg_rdata_i;
      end
   end

   // Host bus drive enable
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) usb_isout_o <= 1'b0;
      else       usb_isout_o <= ~usb_rdn_i & ~usb_cen_i;
   end

   always_comb begin
      case (addr_q)
         cw_bus_pkg::REG_STATUS,
         cw_bus_pkg::REG_TRIG_MASK,
         cw_bus_pkg::REG_TRIG_MODE,
         cw_bus_pkg::REG_TRIG_COUNT,
         cw_bus_pkg::REG_TARGET_PWR,
         cw_bus_pkg::REG_TARGET_PROG: addr_mapped = 1'b1;
         default:                     addr_mapped = 1'b0;
      endcase
   end

   assign reg_addr_o  = addr_q;
   assign reg_wdata_o = din_q;
   assign bus_error_o = (reg_write_o | reg_read_o) & ~addr_mapped;

endmodule

`default_nettype wire

//--- cw_target_pkg.sv
`default_nettype none

package cw_target_pkg;

   // Target IO lines that can feed the trigger
   localparam int NUM_TRIG_IO = 4;

   // Trigger combine modes, value 3 falls back to OR
   typedef enum logic [1:0] {
      TRIG_OR   = 2'd0,  // Any masked line high
      TRIG_AND  = 2'd1,  // All masked lines high, mask non zero
      TRIG_NAND = 2'd2   // Inverse of AND
   } trig_mode_e;

   // Bit in REG_TARGET_PWR
   localparam int PWR_ON_BIT = 0;

   // Bits in REG_TARGET_PROG
   localparam int PROG_AVR_BIT      = 0;  // AVR programming pass-through
   localparam int PROG_NRST_EN_BIT  = 1;  // Drive the reset pin
   localparam int PROG_NRST_VAL_BIT = 2;  // Level on the reset pin

endpackage

`default_nettype wire

//--- cw_bus_pkg.sv
`default_nettype none

package cw_bus_pkg;

   // Register bus widths
   localparam int DATA_W = 8;
   localparam int ADDR_W = 8;

   // Mapped register addresses, anything else is an unmapped access
   typedef enum logic [ADDR_W-1:0] {
      // Sticky error in bit 0, PLL lock in bit 1
      REG_STATUS      = 8'h10,

      // Trigger routing
      REG_TRIG_MASK   = 8'h20,  // Low 4 bits select target IO lines
      REG_TRIG_MODE   = 8'h21,  // See cw_target_pkg::trig_mode_e
      REG_TRIG_COUNT  = 8'h22,  // 16 bit edge count, two bytes

      // Target pin control
      REG_TARGET_PWR  = 8'h30,  // Bit 0 powers the target
      REG_TARGET_PROG = 8'h31   // AVR programming and reset pin bits
   } reg_addr_e;

endpackage

`default_nettype wire
